// ==== src/retire_pkg.sv ====
package retire_pkg;

  // datapath widths
  localparam int data_width      = 64;  // result values and register contents
  localparam int reg_addr_width  = 5;   // architectural register index
  localparam int arch_reg_count  = 32;  // number of architectural registers

  // reorder buffer geometry
  localparam int rob_depth       = 8;   // entries in flight
  localparam int rob_tag_width   = 3;   // entry index, also the dispatch tag
  localparam int rob_count_width = 4;   // occupancy 0 to 8

  // retired instruction counter
  localparam int count_width     = 32;  // wraps at the top

  // host read port
  localparam int wb_addr_width   = 6;   // word address
  localparam logic [wb_addr_width-1:0] wb_count_addr = 6'd32;  // counter lives here

  // retire state encodings
  // the decode of the two head flags picks one of the last three,
  // idle only appears straight after reset
  localparam logic [1:0] retire_idle      = 2'b00;  // after reset
  localparam logic [1:0] retire_both      = 2'b01;  // two entries retired
  localparam logic [1:0] retire_head_only = 2'b10;  // oldest entry only
  localparam logic [1:0] retire_none      = 2'b11;  // nothing retired

endpackage

// ==== src/rob_buffer.sv ====
`timescale 1ns/1ps

module rob_buffer
  import retire_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      dispatch_valid,
  input  logic [reg_addr_width-1:0] dispatch_dest,
  output logic                      dispatch_ready,
  output logic [rob_tag_width-1:0]  dispatch_tag,

  input  logic                      complete_valid,
  input  logic [rob_tag_width-1:0]  complete_tag,
  input  logic [data_width-1:0]     complete_value,

  input  logic [1:0]                retire_count,

  output logic                      head_valid1,
  output logic                      head_valid2,
  output logic                      head_complete1,
  output logic                      head_complete2,
  output logic [reg_addr_width-1:0] head_dest1,
  output logic [reg_addr_width-1:0] head_dest2,
  output logic [data_width-1:0]     head_value1,
  output logic [data_width-1:0]     head_value2
);

  logic [reg_addr_width-1:0]  entry_dest [rob_depth];
  logic [data_width-1:0]      entry_value [rob_depth];
  logic [rob_depth-1:0]       entry_complete;

  logic [rob_tag_width-1:0]   head_ptr;
  logic [rob_tag_width-1:0]   head_second;  // head plus one, wraps
  logic [rob_tag_width-1:0]   tail_ptr;
  logic [rob_count_width-1:0] occupancy;
  logic                       dispatch_fire;

  assign dispatch_ready = (occupancy != rob_count_width'(rob_depth));  // full stalls dispatch
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign dispatch_tag   = tail_ptr;

  assign head_second = head_ptr + rob_tag_width'(1);

  // oldest two entries, second one may sit at index 0 after a wrap
  assign head_valid1    = (occupancy != '0);
  assign head_valid2    = (occupancy > rob_count_width'(1));
  assign head_complete1 = entry_complete[head_ptr];
  assign head_complete2 = entry_complete[head_second];
  assign head_dest1     = entry_dest[head_ptr];
  assign head_dest2     = entry_dest[head_second];
  assign head_value1    = entry_value[head_ptr];
  assign head_value2    = entry_value[head_second];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (dispatch_fire)
        tail_ptr <= tail_ptr + rob_tag_width'(1);
      head_ptr  <= head_ptr + rob_tag_width'(retire_count);  // pop 0, 1 or 2
      occupancy <= occupancy + rob_count_width'(dispatch_fire)
                   - rob_count_width'(retire_count);
    end
  end

  // complete flags, cleared as entries are freed
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      entry_complete <= '0;
    end
    else
    begin
      if (retire_count != 2'd0)
        entry_complete[head_ptr] <= 1'b0;
      if (retire_count == 2'd2)
        entry_complete[head_second] <= 1'b0;
      if (complete_valid)
        entry_complete[complete_tag] <= 1'b1;  // never an entry being popped
    end
  end

  // entry payload
  always_ff @(posedge clock)
  begin
    if (dispatch_fire)
      entry_dest[tail_ptr] <= dispatch_dest;
    if (complete_valid)
      entry_value[complete_tag] <= complete_value;
  end

endmodule

// ==== src/retire_control.sv ====
`timescale 1ns/1ps

module retire_control
  import retire_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      head_valid1,
  input  logic                      head_valid2,
  input  logic                      head_complete1,
  input  logic                      head_complete2,
  input  logic [reg_addr_width-1:0] head_dest1,
  input  logic [reg_addr_width-1:0] head_dest2,
  input  logic [data_width-1:0]     head_value1,
  input  logic [data_width-1:0]     head_value2,

  output logic [1:0]                retire_count,
  output logic                      write_enable1,
  output logic                      write_enable2,
  output logic [reg_addr_width-1:0] write_dest1,
  output logic [reg_addr_width-1:0] write_dest2,
  output logic [data_width-1:0]     write_value1,
  output logic [data_width-1:0]     write_value2
);

  logic [1:0] state;
  logic [1:0] next_state;
  logic       retire_first;
  logic       retire_second;

  // second entry only goes together with the oldest
  always_comb
  begin
    if (head_valid1 && head_complete1 && head_valid2 && head_complete2)
      next_state = retire_both;
    else if (head_valid1 && head_complete1)
      next_state = retire_head_only;
    else
      next_state = retire_none;
  end

  assign retire_first  = (next_state == retire_both) || (next_state == retire_head_only);
  assign retire_second = (next_state == retire_both);
  assign retire_count  = retire_second ? 2'd2 : (retire_first ? 2'd1 : 2'd0);

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= retire_idle;
    else
      state <= next_state;
  end

  assign write_enable1 = (state == retire_both) || (state == retire_head_only);
  assign write_enable2 = (state == retire_both);

  // retiring pairs, idle lane zeroed
  always_ff @(posedge clock)
  begin
    write_dest1  <= retire_first  ? head_dest1  : '0;
    write_value1 <= retire_first  ? head_value1 : '0;
    write_dest2  <= retire_second ? head_dest2  : '0;
    write_value2 <= retire_second ? head_value2 : '0;
  end

endmodule

// ==== src/retire_counter.sv ====
`timescale 1ns/1ps

module retire_counter
  import retire_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic [1:0]             retire_count,
  output logic [count_width-1:0] retired_total
);

  logic [count_width-1:0] count_step;

  // 0, 1 or 2 per cycle
  assign count_step = count_width'(retire_count);

  // progress measure for the host, read over the bus
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      retired_total <= '0;
    end
    else
    begin
      retired_total <= retired_total + count_step;  // wraps at 2**32
    end
  end

endmodule

// ==== src/arch_register_file.sv ====
`timescale 1ns/1ps

module arch_register_file
  import retire_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      write_enable1,
  input  logic                      write_enable2,
  input  logic [reg_addr_width-1:0] write_dest1,
  input  logic [reg_addr_width-1:0] write_dest2,
  input  logic [data_width-1:0]     write_value1,
  input  logic [data_width-1:0]     write_value2,

  input  logic [count_width-1:0]    retired_total,

  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [wb_addr_width-1:0]  wb_adr,
  input  logic [data_width-1:0]     wb_dat_in,
  output logic [data_width-1:0]     wb_dat_out,
  output logic                      wb_ack
);

  logic [data_width-1:0] regs [arch_reg_count];
  logic [data_width-1:0] read_data;
  logic                  wb_request;

  // lane 2 is the younger instruction, so it is applied last
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < arch_reg_count; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 1; i < arch_reg_count; i++)  // register 0 never written
      begin
        if (write_enable1 && (write_dest1 == reg_addr_width'(i)))
          regs[i] <= write_value1;
        if (write_enable2 && (write_dest2 == reg_addr_width'(i)))
          regs[i] <= write_value2;
      end
    end
  end

  assign wb_request = wb_cyc && wb_stb && !wb_ack;  // one ack per strobe

  always_comb
  begin
    if (wb_we)
      read_data = wb_dat_in;  // write echoed back, nothing stored
    else if (wb_adr == wb_count_addr)
      read_data = data_width'(retired_total);
    else if (wb_adr < wb_addr_width'(arch_reg_count))
      read_data = regs[wb_adr[reg_addr_width-1:0]];
    else
      read_data = '0;  // unmapped
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      wb_ack <= 1'b0;
    else
      wb_ack <= wb_request;
  end

  always_ff @(posedge clock)
  begin
    if (wb_request)
      wb_dat_out <= read_data;  // held for the ack cycle
  end

endmodule

// ==== src/retire_unit_top.sv ====
`timescale 1ns/1ps

module retire_unit_top
  import retire_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      dispatch_valid,
  input  logic [reg_addr_width-1:0] dispatch_dest,
  output logic                      dispatch_ready,
  output logic [rob_tag_width-1:0]  dispatch_tag,

  input  logic                      complete_valid,
  input  logic [rob_tag_width-1:0]  complete_tag,
  input  logic [data_width-1:0]     complete_value,

  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [wb_addr_width-1:0]  wb_adr,
  input  logic [data_width-1:0]     wb_dat_in,
  output logic [data_width-1:0]     wb_dat_out,
  output logic                      wb_ack
);

  // buffer heads into the state machine
  logic                      head_valid1;
  logic                      head_valid2;
  logic                      head_complete1;
  logic                      head_complete2;
  logic [reg_addr_width-1:0] head_dest1;
  logic [reg_addr_width-1:0] head_dest2;
  logic [data_width-1:0]     head_value1;
  logic [data_width-1:0]     head_value2;

  logic [1:0]                retire_count;  // same cycle pop and count

  // registered retire pairs
  logic                      write_enable1;
  logic                      write_enable2;
  logic [reg_addr_width-1:0] write_dest1;
  logic [reg_addr_width-1:0] write_dest2;
  logic [data_width-1:0]     write_value1;
  logic [data_width-1:0]     write_value2;

  logic [count_width-1:0]    retired_total;

  rob_buffer i_rob_buffer (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .complete_value (complete_value),
    .retire_count   (retire_count),
    .head_valid1    (head_valid1),
    .head_valid2    (head_valid2),
    .head_complete1 (head_complete1),
    .head_complete2 (head_complete2),
    .head_dest1     (head_dest1),
    .head_dest2     (head_dest2),
    .head_value1    (head_value1),
    .head_value2    (head_value2)
  );

  retire_control i_retire_control (
    .clock          (clock),
    .reset          (reset),
    .head_valid1    (head_valid1),
    .head_valid2    (head_valid2),
    .head_complete1 (head_complete1),
    .head_complete2 (head_complete2),
    .head_dest1     (head_dest1),
    .head_dest2     (head_dest2),
    .head_value1    (head_value1),
    .head_value2    (head_value2),
    .retire_count   (retire_count),
    .write_enable1  (write_enable1),
    .write_enable2  (write_enable2),
    .write_dest1    (write_dest1),
    .write_dest2    (write_dest2),
    .write_value1   (write_value1),
    .write_value2   (write_value2)
  );

  retire_counter i_retire_counter (
    .clock         (clock),
    .reset         (reset),
    .retire_count  (retire_count),
    .retired_total (retired_total)
  );

  arch_register_file i_arch_register_file (
    .clock         (clock),
    .reset         (reset),
    .write_enable1 (write_enable1),
    .write_enable2 (write_enable2),
    .write_dest1   (write_dest1),
    .write_dest2   (write_dest2),
    .write_value1  (write_value1),
    .write_value2  (write_value2),
    .retired_total (retired_total),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_in     (wb_dat_in),
    .wb_dat_out    (wb_dat_out),
    .wb_ack        (wb_ack)
  );

endmodule

// ==== tests/retire_unit_tb.sv ====
`timescale 1ns/1ps

module retire_unit_tb
  import retire_pkg::*;
();

  localparam int clock_period    = 8;
  localparam int watchdog_cycles = 4000;  // a full register sweep is about 70 cycles

  logic                      clock;
  logic                      reset;
  logic                      dispatch_valid;
  logic [reg_addr_width-1:0] dispatch_dest;
  logic                      dispatch_ready;
  logic [rob_tag_width-1:0]  dispatch_tag;
  logic                      complete_valid;
  logic [rob_tag_width-1:0]  complete_tag;
  logic [data_width-1:0]     complete_value;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [wb_addr_width-1:0]  wb_adr;
  logic [data_width-1:0]     wb_dat_in;
  logic [data_width-1:0]     wb_dat_out;
  logic                      wb_ack;

  // reference model of the architectural state
  logic [data_width-1:0]     model_regs [arch_reg_count];
  logic [count_width-1:0]    model_count;
  logic [rob_tag_width-1:0]  model_tail;
  logic [reg_addr_width-1:0] entry_dest [rob_depth];
  logic [data_width-1:0]     entry_value [rob_depth];
  logic                      entry_done [rob_depth];
  logic [rob_tag_width-1:0]  order_q [$];  // oldest first
  int                        error_count;

  retire_unit_top i_dut (.*);

  always #(clock_period / 2) clock = ~clock;

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    error_count++;
  endtask

  function automatic logic [reg_addr_width-1:0] random_dest();
    return reg_addr_width'(($urandom % 31) + 1);  // 1 to 31
  endfunction

  function automatic logic [data_width-1:0] random_value();
    return {$urandom, $urandom};
  endfunction

  // in-order commit of every completed entry at the front
  function automatic void retire_in_order();
    while (order_q.size() > 0 && entry_done[order_q[0]])
    begin
      if (entry_dest[order_q[0]] != '0)
        model_regs[entry_dest[order_q[0]]] = entry_value[order_q[0]];
      model_count = model_count + count_width'(1);
      entry_done[order_q[0]] = 1'b0;
      void'(order_q.pop_front());
    end
  endfunction

  task automatic dispatch_one(input logic [reg_addr_width-1:0] dest,
                              output logic [rob_tag_width-1:0] tag);
    int waited;
    waited = 0;
    dispatch_valid = 1'b1;
    dispatch_dest  = dest;
    while (!dispatch_ready && waited < 50)
    begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (!dispatch_ready)
    begin
      $display("Timeout: dispatch_ready stayed low for destination %0d", dest);
      error_count++;
    end
    tag = dispatch_tag;
    if (tag !== model_tail)
      report_mismatch($sformatf("dispatch tag %0d, expected %0d", tag, model_tail));
    @(posedge clock);  // transfer edge
    #1;
    dispatch_valid = 1'b0;
    entry_dest[tag] = dest;
    entry_done[tag] = 1'b0;
    order_q.push_back(tag);
    model_tail = model_tail + rob_tag_width'(1);
  endtask

  task automatic complete_one(input logic [rob_tag_width-1:0] tag,
                              input logic [data_width-1:0] value);
    complete_valid = 1'b1;
    complete_tag   = tag;
    complete_value = value;
    @(posedge clock);
    #1;
    complete_valid = 1'b0;
    entry_value[tag] = value;
    entry_done[tag]  = 1'b1;
    retire_in_order();
  endtask

  task automatic wb_access(input logic write, input logic [wb_addr_width-1:0] addr,
                           input logic [data_width-1:0] wdata,
                           output logic [data_width-1:0] rdata);
    int waited;
    waited = 0;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = write;
    wb_adr    = addr;
    wb_dat_in = wdata;
    @(posedge clock);
    #1;
    while (!wb_ack && waited < 20)
    begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (!wb_ack)
    begin
      $display("Timeout: no Wishbone ack for address %0d", addr);
      error_count++;
    end
    rdata  = wb_dat_out;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [wb_addr_width-1:0] addr,
                         output logic [data_width-1:0] data);
    wb_access(1'b0, addr, '0, data);
  endtask

  task automatic settle();
    repeat (4) @(posedge clock);
    #1;
  endtask

  task automatic compare_all_state();
    logic [data_width-1:0] data;
    for (int i = 0; i < arch_reg_count; i++)
    begin
      wb_read(wb_addr_width'(i), data);
      if (data !== model_regs[i])
        report_mismatch($sformatf("register %0d read %h, expected %h", i, data, model_regs[i]));
    end
    wb_read(wb_count_addr, data);
    if (data !== data_width'(model_count))
      report_mismatch($sformatf("retire count %0d, expected %0d", data, model_count));
  endtask

  task automatic check_reset_state();
    if (dispatch_ready !== 1'b1)
      report_mismatch("dispatch_ready low after reset");
    if (wb_ack !== 1'b0)
      report_mismatch("wb_ack high after reset");
    compare_all_state();
  endtask

  task automatic in_order_pairs();
    logic [rob_tag_width-1:0] tags [4];
    for (int i = 0; i < 4; i++)
      dispatch_one(random_dest(), tags[i]);
    for (int i = 0; i < 4; i++)
      complete_one(tags[i], random_value());
    settle();
    compare_all_state();
  endtask

  task automatic out_of_order_completion();
    logic [rob_tag_width-1:0] tags [3];
    for (int i = 0; i < 3; i++)
      dispatch_one(random_dest(), tags[i]);
    complete_one(tags[2], random_value());
    complete_one(tags[1], random_value());
    settle();
    compare_all_state();  // head still pending, nothing retired
    complete_one(tags[0], random_value());
    settle();
    compare_all_state();
  endtask

  task automatic single_retirement();
    logic [rob_tag_width-1:0] tags [3];
    for (int i = 0; i < 3; i++)
      dispatch_one(random_dest(), tags[i]);
    complete_one(tags[0], random_value());
    settle();
    compare_all_state();  // only the oldest has gone
    complete_one(tags[2], random_value());
    complete_one(tags[1], random_value());
    settle();
    compare_all_state();
  endtask

  task automatic back_pressure();
    logic [rob_tag_width-1:0]  tags [8];
    logic [rob_tag_width-1:0]  held_tag;
    logic [rob_tag_width-1:0]  next_tag;
    logic [reg_addr_width-1:0] held_dest;
    for (int i = 0; i < 8; i++)
      dispatch_one(random_dest(), tags[i]);
    if (dispatch_ready !== 1'b0)
      report_mismatch("dispatch_ready high with eight entries held");
    next_tag  = model_tail;
    held_dest = random_dest();
    dispatch_valid = 1'b1;  // ninth request held by the source
    dispatch_dest  = held_dest;
    repeat (3)
    begin
      @(posedge clock);
      #1;
      if (dispatch_ready !== 1'b0 || dispatch_tag !== next_tag)
        report_mismatch($sformatf("ninth dispatch taken, tail now %0d", dispatch_tag));
    end
    for (int i = 7; i >= 0; i--)
      complete_one(tags[i], random_value());  // oldest last keeps the buffer full
    dispatch_one(held_dest, held_tag);
    complete_one(held_tag, random_value());
    settle();
    compare_all_state();
  endtask

  task automatic register_zero_and_bus();
    logic [rob_tag_width-1:0] tags [2];
    logic [data_width-1:0]    data;
    dispatch_one('0, tags[0]);
    dispatch_one('0, tags[1]);
    complete_one(tags[1], random_value());
    complete_one(tags[0], random_value());  // pair retires into register 0
    settle();
    compare_all_state();
    wb_access(1'b1, wb_addr_width'(5), random_value(), data);
    wb_access(1'b1, wb_count_addr, random_value(), data);
    compare_all_state();  // bus writes are dropped
    wb_read(wb_addr_width'(33), data);
    if (data !== '0)
      report_mismatch($sformatf("address 33 read %h, expected 0", data));
    wb_read(wb_addr_width'(63), data);
    if (data !== '0)
      report_mismatch($sformatf("address 63 read %h, expected 0", data));
  endtask

  initial
  begin
    #(watchdog_cycles * clock_period);
    $display("Timeout: run did not finish within %0d clock periods", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(65));
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    complete_value = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_in      = '0;
    model_count    = '0;
    model_tail     = '0;
    error_count    = 0;
    for (int i = 0; i < arch_reg_count; i++)
      model_regs[i] = '0;
    for (int i = 0; i < rob_depth; i++)
      entry_done[i] = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    in_order_pairs();
    out_of_order_completion();
    single_retirement();
    back_pressure();
    register_zero_and_bus();
    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
src/retire_pkg.sv
src/rob_buffer.sv
src/retire_control.sv
src/retire_counter.sv
src/arch_register_file.sv
src/retire_unit_top.sv
tests/retire_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the retire unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module retire_unit_tb \
    -f project.f -o retire_unit_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/retire_unit_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
